// File: design/cw_config.svh
`ifndef CW_CONFIG_SVH
`define CW_CONFIG_SVH

// register bus addresses
`define CW_EXTCLK_ADDR        6'd38
`define CW_TRIGSRC_ADDR       6'd39
`define CW_TRIGMOD_ADDR       6'd40
`define CW_IOROUTE_ADDR       6'd55

// reset values, pin 1 drives tx, pin 2 receives rx
`define CW_EXTCLK_RESET       8'h03
`define CW_TRIGSRC_RESET      8'h01
`define CW_TRIGMOD_RESET      8'h00
`define CW_IOROUTE_RESET      64'h0000_0000_0000_0201

`define CW_IOROUTE_BYTES      16'd8     // routing register read length
`define CW_PIN_COUNT          4         // target io pins

// bit offsets inside one pin's routing byte
`define CW_RT_TX              0
`define CW_RT_RX              1
`define CW_RT_USIO            2
`define CW_RT_USII            3
`define CW_RT_USOC            4         // usi out, open collector, pin 3 only
`define CW_RT_TXOC            5         // uart tx, open collector, pin 3 only
`define CW_RT_GPIO_VAL        6
`define CW_RT_GPIO_EN         7

// bit positions inside the whole routing word
`define CW_RT_AVRPROG         40
`define CW_RT_PWR_OFF         41
`define CW_RT_PWR_FAST        42
`define CW_RT_NRST_EN         48        // first of six static gpio bits

// target power soft start
`define CW_PWM_WIDTH          11
`define CW_PWM_ON_THRESHOLD   1400
`define CW_SOFTSTART_PERIODS  16383

`endif

// File: design/cw_io_ctrl.sv
`include "cw_config.svh"
`default_nettype none

module cw_io_ctrl #(
	parameter int SOFTSTART_PERIODS = `CW_SOFTSTART_PERIODS
) (
	input  logic                     clk,
	input  logic                     reset,
	input  cw_pkg::reg_addr_t        reg_address_i,
	input  cw_pkg::byte_cnt_t        reg_bytecnt_i,
	input  cw_pkg::reg_byte_t        reg_datai_i,
	input  logic                     reg_read_i,
	input  logic                     reg_write_i,
	input  logic                     reg_addrvalid_i,
	input  cw_pkg::reg_addr_t        reg_hypaddress_i,
	output cw_pkg::reg_byte_t        reg_datao_o,
	output cw_pkg::byte_cnt_t        reg_hyplen_o,
	input  logic [5:0]               ext_lines_i,     // fa, fb, io1 .. io4
	input  logic                     advio_i,
	input  logic                     anapattern_i,
	input  logic                     decodedio_i,
	input  logic                     mmc_i,
	output logic                     trigger_ext_o,
	output logic                     trigger_o,       // to capture
	input  logic [`CW_PIN_COUNT-1:0] targetio_i,
	output logic [`CW_PIN_COUNT-1:0] targetio_o,
	output logic [`CW_PIN_COUNT-1:0] targetio_oe_o,
	input  logic                     uart_tx_i,
	output logic                     uart_rx_o,
	input  logic                     usi_out_i,
	output logic                     usi_in_o,
	output logic                     enable_avrprog_o,
	output logic                     enable_output_nrst_o,
	output logic                     output_nrst_o,
	output logic                     enable_output_pdid_o,
	output logic                     output_pdid_o,
	output logic                     enable_output_pdic_o,
	output logic                     output_pdic_o,
	output logic                     targetpower_off_o,
	output logic                     led_auxi_o,
	output logic                     led_auxo_o
);

	cw_pkg::reg_byte_t   extclk;
	cw_pkg::reg_byte_t   trigsrc;
	cw_pkg::reg_byte_t   trigmod;
	cw_pkg::route_word_t route;
	logic                power_off_q;  // also the pin high-z condition

	cw_reg_bank u_reg_bank (
		.clk(clk), .reset(reset),
		.reg_address_i(reg_address_i), .reg_bytecnt_i(reg_bytecnt_i),
		.reg_datai_i(reg_datai_i), .reg_read_i(reg_read_i), .reg_write_i(reg_write_i),
		.reg_addrvalid_i(reg_addrvalid_i), .reg_hypaddress_i(reg_hypaddress_i),
		.reg_datao_o(reg_datao_o), .reg_hyplen_o(reg_hyplen_o),
		.extclk_o(extclk), .trigsrc_o(trigsrc), .trigmod_o(trigmod), .route_o(route)
	);

	cw_trigger_router u_trigger_router (
		.trigsrc_i(trigsrc), .trigmod_i(trigmod), .ext_lines_i(ext_lines_i),
		.advio_i(advio_i), .anapattern_i(anapattern_i), .decodedio_i(decodedio_i),
		.mmc_i(mmc_i), .trigger_ext_o(trigger_ext_o), .trigger_o(trigger_o)
	);

	cw_target_io_router u_target_io_router (
		.route_i(route), .power_off_i(power_off_q), .targetio_i(targetio_i),
		.uart_tx_i(uart_tx_i), .usi_out_i(usi_out_i),
		.targetio_o(targetio_o), .targetio_oe_o(targetio_oe_o),
		.uart_rx_o(uart_rx_o), .usi_in_o(usi_in_o)
	);

	cw_target_power #(.SOFTSTART_PERIODS(SOFTSTART_PERIODS)) u_target_power (
		.clk(clk), .reset(reset),
		.pwr_off_req_i(route[`CW_RT_PWR_OFF]), .fast_start_i(route[`CW_RT_PWR_FAST]),
		.power_off_q_o(power_off_q), .targetpower_off_o(targetpower_off_o)
	);

	assign enable_avrprog_o     = route[`CW_RT_AVRPROG];

	// static gpio, enable and value pairs
	assign enable_output_nrst_o = route[`CW_RT_NRST_EN];
	assign output_nrst_o        = route[`CW_RT_NRST_EN + 1];
	assign enable_output_pdid_o = route[`CW_RT_NRST_EN + 2];
	assign output_pdid_o        = route[`CW_RT_NRST_EN + 3];
	assign enable_output_pdic_o = route[`CW_RT_NRST_EN + 4];
	assign output_pdic_o        = route[`CW_RT_NRST_EN + 5];

	assign led_auxi_o = trigsrc[0];                          // front panel a used as trigger
	assign led_auxo_o = extclk[4] | extclk[3] | trigmod[3];  // aux line driven out

endmodule

`default_nettype wire

// File: design/cw_pkg.sv
`default_nettype none

package cw_pkg;

	typedef logic [5:0]  reg_addr_t;    // register bus address
	typedef logic [7:0]  reg_byte_t;    // register bus data byte
	typedef logic [15:0] byte_cnt_t;    // byte index and length
	typedef logic [63:0] route_word_t;  // target io routing register

	// how the selected external trigger lines are combined, trigsrc[7:6]
	typedef enum logic [1:0] {
		OR   = 2'b00,
		AND  = 2'b01,
		NAND = 2'b10,
		OFF  = 2'b11   // constant low
	} trig_combine_e;

	// trigger module feeding capture, trigmod[2:0]
	typedef enum logic [2:0] {
		EDGE       = 3'd0,  // combined external line
		ADVIO      = 3'd1,
		ANAPATTERN = 3'd2,
		DECODEDIO  = 3'd3,
		MMC        = 3'd4,
		NONE       = 3'd5   // 6 and 7 also give no trigger
	} trig_module_e;

endpackage

`default_nettype wire

// File: design/cw_reg_bank.sv
`include "cw_config.svh"
`default_nettype none

module cw_reg_bank (
	input  logic                clk,
	input  logic                reset,
	input  cw_pkg::reg_addr_t   reg_address_i,
	input  cw_pkg::byte_cnt_t   reg_bytecnt_i,    // byte within routing register
	input  cw_pkg::reg_byte_t   reg_datai_i,
	input  logic                reg_read_i,
	input  logic                reg_write_i,
	input  logic                reg_addrvalid_i,
	input  cw_pkg::reg_addr_t   reg_hypaddress_i,
	output cw_pkg::reg_byte_t   reg_datao_o,
	output cw_pkg::byte_cnt_t   reg_hyplen_o,
	output cw_pkg::reg_byte_t   extclk_o,
	output cw_pkg::reg_byte_t   trigsrc_o,
	output cw_pkg::reg_byte_t   trigmod_o,
	output cw_pkg::route_word_t route_o
);

	localparam int SEL_W = $clog2(`CW_IOROUTE_BYTES);

	cw_pkg::reg_byte_t   extclk_q;
	cw_pkg::reg_byte_t   trigsrc_q;
	cw_pkg::reg_byte_t   trigmod_q;
	cw_pkg::route_word_t route_q;

	cw_pkg::reg_byte_t   rd_data_q;   // captured read byte
	logic                rd_valid_q;  // previous cycle had a valid known address
	logic                addr_known;
	logic [SEL_W-1:0]    route_sel;

	assign route_sel = reg_bytecnt_i[SEL_W-1:0];

	// address decode shared by the valid flag
	always_comb begin
		case (reg_address_i)
			`CW_EXTCLK_ADDR,
			`CW_TRIGSRC_ADDR,
			`CW_TRIGMOD_ADDR,
			`CW_IOROUTE_ADDR: addr_known = 1'b1;
			default:          addr_known = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			extclk_q  <= `CW_EXTCLK_RESET;
			trigsrc_q <= `CW_TRIGSRC_RESET;
			trigmod_q <= `CW_TRIGMOD_RESET;
			route_q   <= `CW_IOROUTE_RESET;
		end else if (reg_write_i) begin
			case (reg_address_i)
				`CW_EXTCLK_ADDR:  extclk_q  <= reg_datai_i;
				`CW_TRIGSRC_ADDR: trigsrc_q <= reg_datai_i;
				`CW_TRIGMOD_ADDR: trigmod_q <= reg_datai_i;
				`CW_IOROUTE_ADDR: route_q[{route_sel, 3'b000} +: 8] <= reg_datai_i; // one byte
				default: ;  // unknown address is ignored
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			rd_valid_q <= 1'b0;
		else
			rd_valid_q <= reg_addrvalid_i & addr_known;
	end

	// read data holds until the next read
	always_ff @(posedge clk) begin
		if (reg_read_i) begin
			case (reg_address_i)
				`CW_EXTCLK_ADDR:  rd_data_q <= extclk_q;
				`CW_TRIGSRC_ADDR: rd_data_q <= trigsrc_q;
				`CW_TRIGMOD_ADDR: rd_data_q <= trigmod_q;
				`CW_IOROUTE_ADDR: rd_data_q <= route_q[{route_sel, 3'b000} +: 8];
				default:          rd_data_q <= '0;
			endcase
		end
	end

	assign reg_datao_o = rd_valid_q ? rd_data_q : '0;

	// length lookup for the bus master, no clock involved
	always_comb begin
		case (reg_hypaddress_i)
			`CW_EXTCLK_ADDR,
			`CW_TRIGSRC_ADDR,
			`CW_TRIGMOD_ADDR: reg_hyplen_o = 16'd1;
			`CW_IOROUTE_ADDR: reg_hyplen_o = `CW_IOROUTE_BYTES;
			default:          reg_hyplen_o = '0;
		endcase
	end

	assign extclk_o  = extclk_q;
	assign trigsrc_o = trigsrc_q;
	assign trigmod_o = trigmod_q;
	assign route_o   = route_q;

	// master must stay inside the routing word, upper bytecnt bits are dropped
	route_bytecnt_in_range: assert property (@(posedge clk) disable iff (reset)
		(reg_write_i && reg_address_i == `CW_IOROUTE_ADDR) |-> reg_bytecnt_i < `CW_IOROUTE_BYTES)
		else $error("routing write with byte count %0d", reg_bytecnt_i);

endmodule

`default_nettype wire

// File: design/cw_target_io_router.sv
`include "cw_config.svh"
`default_nettype none

module cw_target_io_router (
	input  cw_pkg::route_word_t      route_i,
	input  logic                     power_off_i,    // target unpowered, pins go high-z
	input  logic [`CW_PIN_COUNT-1:0] targetio_i,
	input  logic                     uart_tx_i,
	input  logic                     usi_out_i,
	output logic [`CW_PIN_COUNT-1:0] targetio_o,
	output logic [`CW_PIN_COUNT-1:0] targetio_oe_o,
	output logic                     uart_rx_o,
	output logic                     usi_in_o
);

	localparam int OC_PIN   = 2;                  // pin 3, the only open-collector pin
	localparam int LAST_PIN = `CW_PIN_COUNT - 1;  // pin 4, tx and gpio only

	logic [`CW_PIN_COUNT-1:0] pin_drv;
	logic [`CW_PIN_COUNT-1:0] pin_en;

	// pin drive, first matching source wins
	always_comb begin
		for (int p = 0; p < `CW_PIN_COUNT; p++) begin
			pin_drv[p] = 1'b0;
			pin_en[p]  = 1'b0;
			if (route_i[p*8 + `CW_RT_TX]) begin
				pin_drv[p] = uart_tx_i;
				pin_en[p]  = 1'b1;
			end else if (p != LAST_PIN && route_i[p*8 + `CW_RT_USIO]) begin
				pin_drv[p] = usi_out_i;
				pin_en[p]  = 1'b1;
			end else if (p == OC_PIN && route_i[p*8 + `CW_RT_USOC]) begin
				pin_en[p]  = ~usi_out_i;  // pull low only, released when high
			end else if (p == OC_PIN && route_i[p*8 + `CW_RT_TXOC]) begin
				pin_en[p]  = ~uart_tx_i;
			end else if (route_i[p*8 + `CW_RT_GPIO_EN]) begin
				pin_drv[p] = route_i[p*8 + `CW_RT_GPIO_VAL];
				pin_en[p]  = 1'b1;
			end
		end
	end

	assign targetio_o    = pin_drv;
	assign targetio_oe_o = pin_en & {`CW_PIN_COUNT{~power_off_i}};  // all released when off

	// receive side, lowest numbered pin has priority so scan downwards
	always_comb begin
		uart_rx_o = 1'b1;  // idle line when nothing routed
		for (int p = LAST_PIN; p >= 0; p--) begin
			if (route_i[p*8 + `CW_RT_RX])
				uart_rx_o = targetio_i[p];
		end
	end

	always_comb begin
		usi_in_o = 1'b1;
		for (int p = LAST_PIN - 1; p >= 0; p--) begin  // pin 4 has no usi input
			if (route_i[p*8 + `CW_RT_USII])
				usi_in_o = targetio_i[p];
		end
	end

	// pins may never drive into an unpowered target
	no_drive_when_off: assert final (!(power_off_i && (|targetio_oe_o)))
		else $error("target pin enabled while power is off, oe %b", targetio_oe_o);

endmodule

`default_nettype wire

// File: design/cw_target_power.sv
`include "cw_config.svh"
`default_nettype none

module cw_target_power #(
	parameter int SOFTSTART_PERIODS = `CW_SOFTSTART_PERIODS
) (
	input  logic clk,
	input  logic reset,
	input  logic pwr_off_req_i,     // routing word power-off bit
	input  logic fast_start_i,      // skip the pwm ramp
	output logic power_off_q_o,
	output logic targetpower_off_o
);

	localparam int CNT_W = $clog2(SOFTSTART_PERIODS + 1);

	logic                     pwr_off_q;
	logic                     pwr_off_prev;
	logic                     soft_armed;    // set by power-on edge
	logic                     soft_active_q;
	logic                     soft_active;
	logic [`CW_PWM_WIDTH-1:0] pwm_cnt;
	logic [CNT_W-1:0]         period_cnt;
	logic                     pwm_off_phase;

	always_ff @(posedge clk) begin
		if (reset) begin
			pwr_off_q    <= 1'b0;  // power on after reset
			pwr_off_prev <= 1'b0;
			soft_armed   <= 1'b0;
		end else begin
			pwr_off_q    <= pwr_off_req_i;
			pwr_off_prev <= pwr_off_q;
			if (pwr_off_prev && !pwr_off_q)
				soft_armed <= 1'b1;  // falling edge, start ramp
			else if (pwr_off_q)
				soft_armed <= 1'b0;
		end
	end

	// free running, wraps every 2048 cycles
	always_ff @(posedge clk) begin
		if (reset)
			pwm_cnt <= '0;
		else
			pwm_cnt <= pwm_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset || !soft_armed) begin
			period_cnt    <= '0;
			soft_active_q <= 1'b0;
		end else if (period_cnt == CNT_W'(SOFTSTART_PERIODS)) begin
			soft_active_q <= 1'b0;  // ramp done, stay on
		end else if (pwm_cnt == '0) begin
			period_cnt    <= period_cnt + 1'b1;
			soft_active_q <= 1'b1;
		end
	end

	assign soft_active   = soft_active_q & ~pwr_off_q;  // power-off overrides at once
	assign pwm_off_phase = pwm_cnt < `CW_PWM_WIDTH'(`CW_PWM_ON_THRESHOLD);

	assign power_off_q_o     = pwr_off_q;
	assign targetpower_off_o = (soft_active && !fast_start_i) ? pwm_off_phase : pwr_off_q;

	power_off_wins: assert property (@(posedge clk) disable iff (reset)
		power_off_q_o |-> targetpower_off_o)
		else $error("target power on while power-off is set");

endmodule

`default_nettype wire

// File: design/cw_trigger_router.sv
`default_nettype none

module cw_trigger_router (
	input  cw_pkg::reg_byte_t trigsrc_i,    // [7:6] combine mode, [5:0] line enables
	input  cw_pkg::reg_byte_t trigmod_i,    // [2:0] module select
	input  logic [5:0]        ext_lines_i,  // fa, fb, io1 .. io4
	input  logic              advio_i,
	input  logic              anapattern_i,
	input  logic              decodedio_i,
	input  logic              mmc_i,
	output logic              trigger_ext_o,
	output logic              trigger_o
);

	cw_pkg::trig_combine_e combine_mode;
	cw_pkg::trig_module_e  module_sel;
	logic [5:0]            line_en;
	logic                  trig_or;
	logic                  trig_and;

	assign line_en = trigsrc_i[5:0];

	// disabled lines are 0 for or, 1 for and
	assign trig_or  = |(ext_lines_i & line_en);
	assign trig_and = &(ext_lines_i | ~line_en);

	always_comb begin
		combine_mode = cw_pkg::trig_combine_e'(trigsrc_i[7:6]);
		case (combine_mode)
			cw_pkg::OR:   trigger_ext_o = trig_or;
			cw_pkg::AND:  trigger_ext_o = trig_and;
			cw_pkg::NAND: trigger_ext_o = ~trig_and;
			default:      trigger_ext_o = 1'b0;  // off
		endcase
	end

	// capture trigger, straight through with no register
	always_comb begin
		module_sel = cw_pkg::trig_module_e'(trigmod_i[2:0]);
		case (module_sel)
			cw_pkg::EDGE:       trigger_o = trigger_ext_o;
			cw_pkg::ADVIO:      trigger_o = advio_i;
			cw_pkg::ANAPATTERN: trigger_o = anapattern_i;
			cw_pkg::DECODEDIO:  trigger_o = decodedio_i;
			cw_pkg::MMC:        trigger_o = mmc_i;
			default:            trigger_o = 1'b0;  // none and the unused codes
		endcase
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+design
design/cw_pkg.sv
design/cw_reg_bank.sv
design/cw_trigger_router.sv
design/cw_target_io_router.sv
design/cw_target_power.sv
design/cw_io_ctrl.sv
verification/tb_clock_gen.sv
verification/tb_cw_io_ctrl.sv

// File: verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 10
) (
	output logic clk_o
);
	timeunit 1ns;
	timeprecision 100ps;

	initial clk_o = 1'b0;  // known level before the first edge

	always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: verification/tb_cw_io_ctrl.sv
`include "cw_config.svh"
`default_nettype none

module tb_cw_io_ctrl;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int SOFT_PERIODS   = 4;      // short ramp, four pwm periods
	localparam int TIMEOUT_CYCLES = 12000;  // ~500 register cycles plus up to five 2048 periods

	logic clk;
	logic reset;
	cw_pkg::reg_addr_t   reg_address_i, reg_hypaddress_i;
	cw_pkg::byte_cnt_t   reg_bytecnt_i, reg_hyplen_o;
	cw_pkg::reg_byte_t   reg_datai_i, reg_datao_o;
	logic                reg_read_i, reg_write_i, reg_addrvalid_i;
	logic [5:0]          ext_lines_i;
	logic                advio_i, anapattern_i, decodedio_i, mmc_i;
	logic                trigger_ext_o, trigger_o;
	logic [3:0]          targetio_i, targetio_o, targetio_oe_o;
	logic                uart_tx_i, uart_rx_o, usi_out_i, usi_in_o;
	logic                enable_avrprog_o, targetpower_off_o, led_auxi_o, led_auxo_o;
	logic                enable_output_nrst_o, output_nrst_o, enable_output_pdid_o;
	logic                output_pdid_o, enable_output_pdic_o, output_pdic_o;

	// reference model state
	cw_pkg::reg_byte_t   m_extclk, m_trigsrc, m_trigmod, m_rd_data;
	cw_pkg::route_word_t m_route;
	logic                m_rd_valid, m_pwr_off_q, m_pwr_off_prev, m_armed, m_active;
	logic [`CW_PWM_WIDTH-1:0] m_pwm;
	int                  m_periods;

	// expected outputs
	cw_pkg::reg_byte_t   exp_datao;
	cw_pkg::byte_cnt_t   exp_hyplen;
	logic                exp_trig_ext, exp_trig, exp_rx, exp_usi_in, exp_pwr_off;
	logic [3:0]          exp_drv, exp_oe;
	logic [6:0]          exp_static, static_out;
	logic [1:0]          exp_leds, leds_out;

	integer seed = 63591;
	int cycle_count = 0;
	int fail_count = 0;
	cw_pkg::reg_addr_t reg_list [4] = '{`CW_EXTCLK_ADDR, `CW_TRIGSRC_ADDR,
		`CW_TRIGMOD_ADDR, `CW_IOROUTE_ADDR};
	cw_pkg::reg_addr_t pick_addr;
	cw_pkg::reg_byte_t rnd_byte;
	logic [2:0]        rnd_idx;

	tb_clock_gen #(.PERIOD_NS(10)) u_clock_gen (.clk_o(clk));

	cw_io_ctrl #(.SOFTSTART_PERIODS(SOFT_PERIODS)) UUT (
		.clk(clk), .reset(reset),
		.reg_address_i(reg_address_i), .reg_bytecnt_i(reg_bytecnt_i),
		.reg_datai_i(reg_datai_i), .reg_read_i(reg_read_i), .reg_write_i(reg_write_i),
		.reg_addrvalid_i(reg_addrvalid_i), .reg_hypaddress_i(reg_hypaddress_i),
		.reg_datao_o(reg_datao_o), .reg_hyplen_o(reg_hyplen_o),
		.ext_lines_i(ext_lines_i), .advio_i(advio_i), .anapattern_i(anapattern_i),
		.decodedio_i(decodedio_i), .mmc_i(mmc_i),
		.trigger_ext_o(trigger_ext_o), .trigger_o(trigger_o),
		.targetio_i(targetio_i), .targetio_o(targetio_o), .targetio_oe_o(targetio_oe_o),
		.uart_tx_i(uart_tx_i), .uart_rx_o(uart_rx_o),
		.usi_out_i(usi_out_i), .usi_in_o(usi_in_o),
		.enable_avrprog_o(enable_avrprog_o),
		.enable_output_nrst_o(enable_output_nrst_o), .output_nrst_o(output_nrst_o),
		.enable_output_pdid_o(enable_output_pdid_o), .output_pdid_o(output_pdid_o),
		.enable_output_pdic_o(enable_output_pdic_o), .output_pdic_o(output_pdic_o),
		.targetpower_off_o(targetpower_off_o),
		.led_auxi_o(led_auxi_o), .led_auxo_o(led_auxo_o)
	);

	assign static_out = {enable_avrprog_o, output_pdic_o, enable_output_pdic_o, output_pdid_o,
		enable_output_pdid_o, output_nrst_o, enable_output_nrst_o};
	assign leds_out   = {led_auxi_o, led_auxo_o};

	function automatic logic addr_known(cw_pkg::reg_addr_t a);
		return a == `CW_EXTCLK_ADDR || a == `CW_TRIGSRC_ADDR ||
			a == `CW_TRIGMOD_ADDR || a == `CW_IOROUTE_ADDR;
	endfunction

	// masked lines: 0 for or, 1 for and
	function automatic logic combine_lines(cw_pkg::reg_byte_t src, logic [5:0] lines);
		logic any_hit;
		logic all_hit;
		any_hit = |(lines & src[5:0]);
		all_hit = &(lines | ~src[5:0]);
		case (cw_pkg::trig_combine_e'(src[7:6]))
			cw_pkg::OR:   return any_hit;
			cw_pkg::AND:  return all_hit;
			cw_pkg::NAND: return !all_hit;
			default:      return 1'b0;
		endcase
	endfunction

	// returns {enables, values}, first matching source per pin wins
	function automatic logic [7:0] pin_drive(cw_pkg::route_word_t r, logic tx, logic uso);
		logic [3:0] drv;
		logic [3:0] en;
		logic [7:0] b;
		drv = '0;
		en  = '0;
		for (int p = 0; p < `CW_PIN_COUNT; p++) begin
			b = r[p*8 +: 8];
			if (b[`CW_RT_TX]) begin
				drv[p] = tx;
				en[p]  = 1'b1;
			end else if (p != 3 && b[`CW_RT_USIO]) begin
				drv[p] = uso;
				en[p]  = 1'b1;
			end else if (p == 2 && b[`CW_RT_USOC]) begin
				en[p]  = !uso;  // open collector pulls low only
			end else if (p == 2 && b[`CW_RT_TXOC]) begin
				en[p]  = !tx;
			end else if (b[`CW_RT_GPIO_EN]) begin
				drv[p] = b[`CW_RT_GPIO_VAL];
				en[p]  = 1'b1;
			end
		end
		return {en, drv};
	endfunction

	function automatic logic first_routed_pin(cw_pkg::route_word_t r, logic [3:0] pins,
		int bit_ofs, int last);
		for (int p = 0; p <= last; p++) begin
			if (r[p*8 + bit_ofs])
				return pins[p];
		end
		return 1'b1;  // idle high when nothing routed
	endfunction

	// register and read path model
	always_ff @(posedge clk) begin
		if (reset) begin
			m_extclk   <= `CW_EXTCLK_RESET;
			m_trigsrc  <= `CW_TRIGSRC_RESET;
			m_trigmod  <= `CW_TRIGMOD_RESET;
			m_route    <= `CW_IOROUTE_RESET;
			m_rd_data  <= '0;
			m_rd_valid <= 1'b0;
		end else begin
			if (reg_write_i) begin
				case (reg_address_i)
					`CW_EXTCLK_ADDR:  m_extclk  <= reg_datai_i;
					`CW_TRIGSRC_ADDR: m_trigsrc <= reg_datai_i;
					`CW_TRIGMOD_ADDR: m_trigmod <= reg_datai_i;
					`CW_IOROUTE_ADDR: m_route[reg_bytecnt_i[2:0]*8 +: 8] <= reg_datai_i;
					default: ;
				endcase
			end
			if (reg_read_i) begin
				case (reg_address_i)
					`CW_EXTCLK_ADDR:  m_rd_data <= m_extclk;
					`CW_TRIGSRC_ADDR: m_rd_data <= m_trigsrc;
					`CW_TRIGMOD_ADDR: m_rd_data <= m_trigmod;
					`CW_IOROUTE_ADDR: m_rd_data <= m_route[reg_bytecnt_i[2:0]*8 +: 8];
					default:          m_rd_data <= '0;
				endcase
			end
			m_rd_valid <= reg_addrvalid_i && addr_known(reg_address_i);
		end
	end

	// power sync and soft start model, pwm counted from reset release
	always_ff @(posedge clk) begin
		if (reset) begin
			m_pwr_off_q    <= 1'b0;
			m_pwr_off_prev <= 1'b0;
			m_armed        <= 1'b0;
			m_pwm          <= '0;
			m_periods      <= 0;
			m_active       <= 1'b0;
		end else begin
			m_pwr_off_q    <= m_route[`CW_RT_PWR_OFF];
			m_pwr_off_prev <= m_pwr_off_q;
			if (m_pwr_off_prev && !m_pwr_off_q)
				m_armed <= 1'b1;  // power came back on
			else if (m_pwr_off_q)
				m_armed <= 1'b0;
			m_pwm <= m_pwm + 1'b1;
			if (!m_armed) begin
				m_periods <= 0;
				m_active  <= 1'b0;
			end else if (m_periods == SOFT_PERIODS) begin
				m_active  <= 1'b0;  // ramp finished
			end else if (m_pwm == 0) begin
				m_periods <= m_periods + 1;
				m_active  <= 1'b1;
			end
		end
	end

	always_comb begin
		exp_datao = m_rd_valid ? m_rd_data : 8'h00;
		case (reg_hypaddress_i)
			`CW_EXTCLK_ADDR, `CW_TRIGSRC_ADDR, `CW_TRIGMOD_ADDR: exp_hyplen = 16'd1;
			`CW_IOROUTE_ADDR: exp_hyplen = 16'd8;
			default:          exp_hyplen = 16'd0;
		endcase
		exp_trig_ext = combine_lines(m_trigsrc, ext_lines_i);
		case (m_trigmod[2:0])
			3'd0:    exp_trig = exp_trig_ext;
			3'd1:    exp_trig = advio_i;
			3'd2:    exp_trig = anapattern_i;
			3'd3:    exp_trig = decodedio_i;
			3'd4:    exp_trig = mmc_i;
			default: exp_trig = 1'b0;
		endcase
		{exp_oe, exp_drv} = pin_drive(m_route, uart_tx_i, usi_out_i);
		exp_oe     = exp_oe & ~{4{m_pwr_off_q}};  // high-z while unpowered
		exp_rx     = first_routed_pin(m_route, targetio_i, `CW_RT_RX, 3);
		exp_usi_in = first_routed_pin(m_route, targetio_i, `CW_RT_USII, 2);
		exp_static = {m_route[`CW_RT_AVRPROG], m_route[`CW_RT_NRST_EN +: 6]};
		exp_leds   = {m_trigsrc[0], m_extclk[4] | m_extclk[3] | m_trigmod[3]};
		exp_pwr_off = (m_active && !m_pwr_off_q && !m_route[`CW_RT_PWR_FAST]) ?
			(m_pwm < `CW_PWM_ON_THRESHOLD) : m_pwr_off_q;
	end

	task automatic stop_on_failure(string reason);
		fail_count++;
		$display("Test failures found");
		$fatal(1, "%s", reason);
	endtask

	task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
		$display("** Error at %0t ns: %s expected 'h%0h, actual 'h%0h",
			$time, name, expected, actual);
		stop_on_failure("output value mismatch");
	endtask

	check_datao: assert property (@(posedge clk) disable iff (reset) reg_datao_o == exp_datao)
		else report_mismatch("reg_datao_o", $sampled(exp_datao), $sampled(reg_datao_o));
	check_hyplen: assert property (@(posedge clk) disable iff (reset) reg_hyplen_o == exp_hyplen)
		else report_mismatch("reg_hyplen_o", $sampled(exp_hyplen), $sampled(reg_hyplen_o));
	check_trig_ext: assert property (@(posedge clk) disable iff (reset)
		trigger_ext_o == exp_trig_ext)
		else report_mismatch("trigger_ext_o", $sampled(exp_trig_ext), $sampled(trigger_ext_o));
	check_trig: assert property (@(posedge clk) disable iff (reset) trigger_o == exp_trig)
		else report_mismatch("trigger_o", $sampled(exp_trig), $sampled(trigger_o));
	check_pin_oe: assert property (@(posedge clk) disable iff (reset) targetio_oe_o == exp_oe)
		else report_mismatch("targetio_oe_o", $sampled(exp_oe), $sampled(targetio_oe_o));
	// pin values only matter where the pin is driven
	check_pin_val: assert property (@(posedge clk) disable iff (reset)
		(targetio_o & exp_oe) == (exp_drv & exp_oe))
		else report_mismatch("targetio_o", $sampled(exp_drv & exp_oe),
			$sampled(targetio_o & exp_oe));
	check_rx: assert property (@(posedge clk) disable iff (reset) uart_rx_o == exp_rx)
		else report_mismatch("uart_rx_o", $sampled(exp_rx), $sampled(uart_rx_o));
	check_usi_in: assert property (@(posedge clk) disable iff (reset) usi_in_o == exp_usi_in)
		else report_mismatch("usi_in_o", $sampled(exp_usi_in), $sampled(usi_in_o));
	check_static: assert property (@(posedge clk) disable iff (reset) static_out == exp_static)
		else report_mismatch("static gpio and avrprog", $sampled(exp_static),
			$sampled(static_out));
	check_leds: assert property (@(posedge clk) disable iff (reset) leds_out == exp_leds)
		else report_mismatch("led_auxi_o/led_auxo_o", $sampled(exp_leds), $sampled(leds_out));
	check_power: assert property (@(posedge clk) disable iff (reset)
		targetpower_off_o == exp_pwr_off)
		else report_mismatch("targetpower_off_o", $sampled(exp_pwr_off),
			$sampled(targetpower_off_o));

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			stop_on_failure("timeout, the run did not finish within the cycle limit");
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;  // drive away from the sampling edge
	endtask

	task automatic write_reg(cw_pkg::reg_addr_t addr, cw_pkg::byte_cnt_t cnt,
		cw_pkg::reg_byte_t data);
		reg_address_i = addr;
		reg_bytecnt_i = cnt;
		reg_datai_i   = data;
		reg_write_i   = 1'b1;
		next_cycle();
		reg_write_i   = 1'b0;
	endtask

	task automatic read_reg(cw_pkg::reg_addr_t addr, cw_pkg::byte_cnt_t cnt, logic valid);
		reg_address_i   = addr;
		reg_bytecnt_i   = cnt;
		reg_read_i      = 1'b1;
		reg_addrvalid_i = valid;
		next_cycle();
		reg_read_i      = 1'b0;
		reg_addrvalid_i = 1'b0;
		next_cycle();  // read byte is on the bus during this cycle
	endtask

	task automatic randomize_inputs();
		ext_lines_i = $random(seed);
		{advio_i, anapattern_i, decodedio_i, mmc_i} = $random(seed);
		targetio_i = $random(seed);
		{uart_tx_i, usi_out_i} = $random(seed);
	endtask

	initial begin
		reset = 1'b1;
		reg_address_i = '0;
		reg_hypaddress_i = '0;
		reg_bytecnt_i = '0;
		reg_datai_i = '0;
		{reg_read_i, reg_write_i, reg_addrvalid_i} = '0;
		ext_lines_i = '0;
		{advio_i, anapattern_i, decodedio_i, mmc_i} = '0;
		targetio_i = '0;
		{uart_tx_i, usi_out_i} = 2'b11;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;

		// reset values and length lookup
		for (int i = 0; i < 3; i++)
			read_reg(reg_list[i], 0, 1'b1);
		for (int i = 0; i < 8; i++)
			read_reg(`CW_IOROUTE_ADDR, i, 1'b1);
		for (int i = 0; i < 4; i++) begin
			reg_hypaddress_i = reg_list[i];
			next_cycle();
		end
		reg_hypaddress_i = 6'd7;  // unknown
		next_cycle();

		// random write then read back, power-off bit held clear
		repeat (24) begin
			pick_addr = reg_list[$unsigned($random(seed)) % 4];
			rnd_byte  = $random(seed);
			rnd_idx   = $random(seed);
			if (pick_addr == `CW_IOROUTE_ADDR && rnd_idx == 3'd5)
				rnd_byte[1] = 1'b0;
			write_reg(pick_addr, rnd_idx, rnd_byte);
			read_reg(pick_addr, rnd_idx, 1'b1);
		end
		write_reg(6'd12, 0, 8'ha5);
		read_reg(6'd12, 0, 1'b1);
		read_reg(`CW_TRIGSRC_ADDR, 0, 1'b0);  // no addrvalid

		// trigger combine and select
		repeat (40) begin
			write_reg(`CW_TRIGSRC_ADDR, 0, $random(seed));
			write_reg(`CW_TRIGMOD_ADDR, 0, $random(seed));
			repeat (4) begin
				randomize_inputs();
				next_cycle();
			end
		end

		// pin routing, static gpio and leds with power on
		repeat (40) begin
			rnd_idx  = $random(seed);
			rnd_byte = $random(seed);
			if (rnd_idx == 3'd4 || rnd_idx == 3'd7)
				rnd_idx = rnd_idx - 1'b1;  // skip unused bytes
			if (rnd_idx == 3'd5)
				rnd_byte[1] = 1'b0;
			write_reg(`CW_IOROUTE_ADDR, rnd_idx, rnd_byte);
			write_reg(`CW_EXTCLK_ADDR, 0, $random(seed));
			repeat (3) begin
				randomize_inputs();
				next_cycle();
			end
		end

		// power off releases every pin
		write_reg(`CW_IOROUTE_ADDR, 0, 8'h01);
		write_reg(`CW_IOROUTE_ADDR, 5, 8'h02);
		repeat (4) next_cycle();

		// slow soft start over four pwm periods
		write_reg(`CW_IOROUTE_ADDR, 5, 8'h00);
		wait (m_periods == SOFT_PERIODS && !m_active);
		repeat (8) next_cycle();

		// fast start skips the ramp
		write_reg(`CW_IOROUTE_ADDR, 5, 8'h02);
		repeat (4) next_cycle();
		write_reg(`CW_IOROUTE_ADDR, 5, 8'h04);
		repeat (8) next_cycle();

		if (fail_count == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			stop_on_failure("checks failed during the run");
		end
	end

endmodule

`default_nettype wire
